// File: rv_pkg.sv
// Shared definitions for the RV64I execute unit.
// Widths, opcode and funct3 values, the ALU operation set,
// the instruction union and the pipeline structs.

package rv_pkg;

    // ------------------------------
    // Widths.
    // ------------------------------
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // ------------------------------
    // Opcodes of the kept classes.
    // ------------------------------
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG_W = 7'b0111011;
    localparam logic [6:0] OP_IMM_W = 7'b0011011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;

    // Funct3 values.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // ALU operations, pass forwards operand b (LUI).
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_PASS = 4'd10
    } alu_op_t;

    // ------------------------------
    // Instruction word, two views.
    // ------------------------------
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [19:0]           upper;   // I imm in [19:8], U imm whole.
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } iu;
    } instr_t;

    // Decoded control, stage 1 to execute.
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  is_word;
        logic                  write_en;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
    } dec_ctrl_t;

    // Writeback result.
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

// File: rv_instr_decoder.sv
// Stage 1 instruction decoder.
// Maps opcode and funct fields to an ALU operation and builds
// the sign-extended immediate, registered with the valid bit.

module rv_instr_decoder
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_valid,
    input  instr_t    i_instr,
    output dec_ctrl_t o_ctrl
);

    // ------------------------------
    // Internal nets.
    // ------------------------------
    dec_ctrl_t       ctrl_d;
    logic            bad_op;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic            alt_bit;

    // Funct3 to ALU operation.
    // SUB only exists in the register forms, SRA uses the same bit everywhere.
    function automatic alu_op_t f3_to_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       sub_en
    );
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = (alt && sub_en) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // Word classes have no compare or logic operations.
    function automatic logic word_f3_ok(input logic [2:0] f3);
        return (f3 == F3_ADD_SUB) || (f3 == F3_SLL) || (f3 == F3_SRL_SRA);
    endfunction

    // ------------------------------
    // Immediates.
    // ------------------------------
    assign imm_i   = {{(XLEN-12){i_instr.iu.upper[19]}}, i_instr.iu.upper[19:8]};
    assign imm_u   = {{(XLEN-32){i_instr.iu.upper[19]}}, i_instr.iu.upper, 12'b0};

    // Instruction bit 30.
    assign alt_bit = i_instr.r.funct7[5];

    // ------------------------------
    // Decode.
    // ------------------------------
    always_comb begin
        ctrl_d         = '0;
        bad_op         = 1'b0;
        ctrl_d.rd      = i_instr.r.rd;
        ctrl_d.rs1     = i_instr.r.rs1;
        ctrl_d.rs2     = i_instr.r.rs2;
        ctrl_d.alu_op  = ALU_ADD;

        case (i_instr.r.opcode)
            OP_REG: begin
                ctrl_d.alu_op = f3_to_op(i_instr.r.funct3, alt_bit, 1'b1);
            end
            OP_IMM: begin
                ctrl_d.alu_op  = f3_to_op(i_instr.r.funct3, alt_bit, 1'b0);
                ctrl_d.use_imm = 1'b1;
                ctrl_d.imm     = imm_i;
            end
            OP_REG_W: begin
                ctrl_d.alu_op  = f3_to_op(i_instr.r.funct3, alt_bit, 1'b1);
                ctrl_d.is_word = 1'b1;
                bad_op         = !word_f3_ok(i_instr.r.funct3);
            end
            OP_IMM_W: begin
                ctrl_d.alu_op  = f3_to_op(i_instr.r.funct3, alt_bit, 1'b0);
                ctrl_d.use_imm = 1'b1;
                ctrl_d.is_word = 1'b1;
                ctrl_d.imm     = imm_i;
                bad_op         = !word_f3_ok(i_instr.r.funct3);
            end
            OP_LUI: begin
                ctrl_d.alu_op  = ALU_PASS;
                ctrl_d.use_imm = 1'b1;
                ctrl_d.imm     = imm_u;
            end
            default: begin
                bad_op = 1'b1;
            end
        endcase

        ctrl_d.valid    = i_valid;
        ctrl_d.illegal  = i_valid && bad_op;
        ctrl_d.write_en = i_valid && !bad_op;
    end

    // ------------------------------
    // Stage register.
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ctrl <= '0;
        end else begin
            o_ctrl <= ctrl_d;
        end
    end

endmodule

// File: rv_regfile.sv
// Register file, 32 x 64.
// Two registered read ports taken from the instruction word,
// one write port fed by writeback, with write-through.

module rv_regfile
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst,
    input  instr_t          i_instr,
    input  wb_t             i_wb,
    output logic [XLEN-1:0] o_rs1_data,
    output logic [XLEN-1:0] o_rs2_data
);

    logic [XLEN-1:0]       regs [NUM_REGS];
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic                  wr_en;
    logic [XLEN-1:0]       rs1_next;
    logic [XLEN-1:0]       rs2_next;

    // One read port.
    // x0 is hardwired, a same-cycle write wins over the array.
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (addr == i_wb.rd)) begin
            data = i_wb.data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_addr = i_instr.r.rs1;
    assign rs2_addr = i_instr.r.rs2;

    // Illegal results never reach the array.
    assign wr_en    = i_wb.valid && !i_wb.illegal && (i_wb.rd != '0);

    always_comb begin
        rs1_next = read_port(rs1_addr);
        rs2_next = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            o_rs1_data <= '0;
            o_rs2_data <= '0;
        end else begin
            if (wr_en) begin
                regs[i_wb.rd] <= i_wb.data;
            end
            o_rs1_data <= rs1_next;
            o_rs2_data <= rs2_next;
        end
    end

endmodule

// File: rv_execute.sv
// Execute stage.
// Forwarding from the writeback register, operand select,
// 64-bit and word-form ALU, and the writeback register.

module rv_execute
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst,
    input  dec_ctrl_t       i_ctrl,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    output wb_t             o_wb
);

    // ------------------------------
    // Internal nets.
    // ------------------------------
    logic            wb_we;
    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] src_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] res_d;
    logic [31:0]     res_w;
    logic [XLEN-1:0] alu_result;
    wb_t             wb_d;

    // ------------------------------
    // Forwarding.
    // ------------------------------
    // Previous instruction is still in flight to the register file.
    assign fwd_rs1 = wb_we && (o_wb.rd != '0) && (o_wb.rd == i_ctrl.rs1);
    assign fwd_rs2 = wb_we && (o_wb.rd != '0) && (o_wb.rd == i_ctrl.rs2);

    assign src_a   = fwd_rs1 ? o_wb.data : i_rs1_data;
    assign rs2_val = fwd_rs2 ? o_wb.data : i_rs2_data;
    assign src_b   = i_ctrl.use_imm ? i_ctrl.imm : rs2_val;

    // Word forms shift by 5 bits only.
    assign shamt   = i_ctrl.is_word ? {1'b0, src_b[4:0]} : src_b[5:0];

    // ------------------------------
    // ALU.
    // ------------------------------
    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:  res_d = src_a + src_b;
            ALU_SUB:  res_d = src_a - src_b;
            ALU_SLL:  res_d = src_a << shamt;
            ALU_SLT:  res_d = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: res_d = {{(XLEN-1){1'b0}}, src_a < src_b};
            ALU_XOR:  res_d = src_a ^ src_b;
            ALU_SRL:  res_d = src_a >> shamt;
            ALU_SRA:  res_d = $signed(src_a) >>> shamt;
            ALU_OR:   res_d = src_a | src_b;
            ALU_AND:  res_d = src_a & src_b;
            ALU_PASS: res_d = src_b;
            default:  res_d = '0;
        endcase
    end

    // 32-bit results, only the low word of the operands.
    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD: res_w = src_a[31:0] + src_b[31:0];
            ALU_SUB: res_w = src_a[31:0] - src_b[31:0];
            ALU_SLL: res_w = src_a[31:0] << shamt[4:0];
            ALU_SRL: res_w = src_a[31:0] >> shamt[4:0];
            ALU_SRA: res_w = $signed(src_a[31:0]) >>> shamt[4:0];
            default: res_w = res_d[31:0];
        endcase
    end

    assign alu_result = i_ctrl.is_word ? {{(XLEN-32){res_w[31]}}, res_w} : res_d;

    // ------------------------------
    // Writeback register.
    // ------------------------------
    always_comb begin
        wb_d.valid   = i_ctrl.valid;
        wb_d.illegal = i_ctrl.valid && i_ctrl.illegal;
        wb_d.rd      = i_ctrl.rd;
        // Illegal instructions report zero.
        wb_d.data    = i_ctrl.illegal ? '0 : alu_result;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb  <= '0;
            wb_we <= 1'b0;
        end else begin
            o_wb  <= wb_d;
            wb_we <= i_ctrl.valid && i_ctrl.write_en;
        end
    end

endmodule

// File: rv_exec_unit.sv
// Top level of the two-stage execute unit.
// Decoder and register file in stage 1, execute in stage 2,
// writeback loops back to the register file.

module rv_exec_unit
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst,
    input  logic   i_valid,
    input  instr_t i_instr,
    output wb_t    o_wb
);

    // ------------------------------
    // Internal nets.
    // ------------------------------
    dec_ctrl_t       ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // Stage 1 decode.
    rv_instr_decoder u_decoder (
        .clk     ( clk     ),
        .i_rst   ( i_rst   ),
        .i_valid ( i_valid ),
        .i_instr ( i_instr ),
        .o_ctrl  ( ctrl    )
    );

    // Stage 1 operand read, written from writeback.
    rv_regfile u_regfile (
        .clk        ( clk      ),
        .i_rst      ( i_rst    ),
        .i_instr    ( i_instr  ),
        .i_wb       ( o_wb     ),
        .o_rs1_data ( rs1_data ),
        .o_rs2_data ( rs2_data )
    );

    // Stage 2 execute.
    rv_execute u_execute (
        .clk        ( clk      ),
        .i_rst      ( i_rst    ),
        .i_ctrl     ( ctrl     ),
        .i_rs1_data ( rs1_data ),
        .i_rs2_data ( rs2_data ),
        .o_wb       ( o_wb     )
    );

endmodule

// File: tb_rv_model.svh
// Instruction encoders and the reference model for the testbench.
// The model follows the RV64I rules of the kept instruction classes.

`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                 input logic [6:0] opc, input logic [4:0] rd,
                                 input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                 input logic [6:0] opc, input logic [4:0] rd,
                                 input logic [4:0] rs1);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OP_LUI};
endfunction

// Expected result of one instruction on the given source values.
function automatic logic [XLEN-1:0] model_result(
    input  instr_t          w,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] rb,
    output logic            bad
);
    logic            reg_form;
    logic            word;
    logic            alt;
    logic [XLEN-1:0] b;
    logic [5:0]      sh;
    logic [31:0]     rw;
    logic [XLEN-1:0] r;
    reg_form = (w.r.opcode == OP_REG) || (w.r.opcode == OP_REG_W);
    word     = (w.r.opcode == OP_REG_W) || (w.r.opcode == OP_IMM_W);
    alt      = w.r.funct7[5];
    b        = reg_form ? rb : {{52{w.iu.upper[19]}}, w.iu.upper[19:8]};
    sh       = word ? {1'b0, b[4:0]} : b[5:0];
    bad      = 1'b0;
    r        = '0;
    rw       = '0;
    if (w.r.opcode == OP_LUI) begin
        r = {{32{w.iu.upper[19]}}, w.iu.upper, 12'h000};
    end else if (!reg_form && !word && (w.r.opcode != OP_IMM)) begin
        bad = 1'b1;
    end else if (!word) begin
        case (w.r.funct3)
            F3_ADD_SUB: r = (reg_form && alt) ? a - b : a + b;
            F3_SLL:     r = a << sh;
            F3_SLT:     r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            F3_SLTU:    r = (a < b) ? 64'd1 : 64'd0;
            F3_XOR:     r = a ^ b;
            F3_SRL_SRA: begin
                if (alt) r = $signed(a) >>> sh;
                else r = a >> sh;
            end
            F3_OR:      r = a | b;
            default:    r = a & b;
        endcase
    end else begin
        // Low word only, then sign-extend.
        case (w.r.funct3)
            F3_ADD_SUB: begin
                if (reg_form && alt) rw = a[31:0] - b[31:0];
                else rw = a[31:0] + b[31:0];
            end
            F3_SLL:     rw = a[31:0] << sh;
            F3_SRL_SRA: begin
                if (alt) rw = $signed(a[31:0]) >>> sh;
                else rw = a[31:0] >> sh;
            end
            default:    bad = 1'b1;
        endcase
        r = bad ? '0 : {{32{rw[31]}}, rw};
    end
    return r;
endfunction

`endif

// File: tb_rv_exec_unit.sv
// Testbench for the two-stage execute unit.
// Table-driven stimulus, shadow register model, in-order result checks.

module tb_rv_exec_unit
    import rv_pkg::*;
();

    `include "tb_rv_model.svh"

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } entry_t;

    logic            clk = 1'b0;
    logic            i_rst;
    logic            i_valid;
    instr_t          i_instr;
    wb_t             o_wb;
    entry_t          table_q [$];
    wb_t             exp_q [$];
    logic [XLEN-1:0] shadow [NUM_REGS];
    int              seed = 63;
    int              errors = 0;
    int              checked = 0;
    int              cycles = 0;
    int              cycle_limit = 0;

    rv_exec_unit dut (
        .clk     ( clk     ),
        .i_rst   ( i_rst   ),
        .i_valid ( i_valid ),
        .i_instr ( i_instr ),
        .o_wb    ( o_wb    )
    );

    always #20 clk = ~clk;

    // ------------------------------
    // Table and model helpers.
    // ------------------------------
    task automatic add_instr(input instr_t w);
        table_q.push_back({1'b1, w});
    endtask

    task automatic add_gap();
        table_q.push_back({1'b0, 32'h0});
    endtask

    task automatic predict_result(input instr_t w);
        logic            bad;
        logic [XLEN-1:0] res;
        wb_t             want;
        res = model_result(w, shadow[w.r.rs1], shadow[w.r.rs2], bad);
        if (!bad && (w.r.rd != 5'd0)) begin
            shadow[w.r.rd] = res;
        end
        want.valid   = 1'b1;
        want.illegal = bad;
        want.rd      = w.r.rd;
        want.data    = res;
        exp_q.push_back(want);
    endtask

    task automatic check_wb(input wb_t got, input wb_t want);
        checked++;
        if (got !== want) begin
            errors++;
            $display("** Error at %0t: o_wb (valid illegal rd data) got %b %b %0d %h, %s %b %b %0d %h",
                     $time, got.valid, got.illegal, got.rd, got.data, "expected",
                     want.valid, want.illegal, want.rd, want.data);
        end
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        // Operand x1 is positive, x2 negative and x3 full width.
        rnd = $random(seed);
        add_instr(enc_u({1'b0, rnd[18:0]}, 5'd1));
        add_instr(enc_i(rnd[31:20], F3_ADD_SUB, OP_IMM, 5'd1, 5'd1));
        rnd = $random(seed);
        add_instr(enc_u({1'b1, rnd[18:0]}, 5'd2));
        add_gap();
        add_instr(enc_i(rnd[31:20], F3_ADD_SUB, OP_IMM, 5'd2, 5'd2));
        add_instr(enc_i(12'd29, F3_SLL, OP_IMM, 5'd3, 5'd1));
        add_instr(enc_r(7'h00, F3_XOR, OP_REG, 5'd3, 5'd3, 5'd2));
        // R-type in both operand orders.
        for (int f = 0; f < 8; f++) begin
            add_instr(enc_r(7'h00, f[2:0], OP_REG, 5'(8 + f), 5'd1, 5'd2));
            add_instr(enc_r(7'h00, f[2:0], OP_REG, 5'(16 + f), 5'd2, 5'd3));
        end
        add_instr(enc_r(7'h20, F3_ADD_SUB, OP_REG, 5'd24, 5'd1, 5'd3));
        add_instr(enc_r(7'h20, F3_SRL_SRA, OP_REG, 5'd25, 5'd2, 5'd1));
        add_instr(enc_r(7'h20, F3_SRL_SRA, OP_REG, 5'd26, 5'd3, 5'd1));
        // I-type with a negative immediate and shifts with 6-bit amounts.
        for (int f = 0; f < 8; f++) begin
            if ((f != 1) && (f != 5)) begin
                add_instr(enc_i(12'h9A5, f[2:0], OP_IMM, 5'(8 + f), 5'd3));
            end
        end
        add_instr(enc_i({6'h00, 6'd37}, F3_SLL, OP_IMM, 5'd9, 5'd3));
        add_instr(enc_i({6'h00, 6'd45}, F3_SRL_SRA, OP_IMM, 5'd13, 5'd2));
        add_instr(enc_i({6'h10, 6'd45}, F3_SRL_SRA, OP_IMM, 5'd14, 5'd2));
        // Word forms with an ADDW overflow.
        add_instr(enc_u(20'h7FFFF, 5'd6));
        add_instr(enc_i(12'h7FF, F3_ADD_SUB, OP_IMM, 5'd6, 5'd6));
        add_instr(enc_r(7'h00, F3_ADD_SUB, OP_REG_W, 5'd7, 5'd6, 5'd6));
        add_instr(enc_r(7'h20, F3_ADD_SUB, OP_REG_W, 5'd18, 5'd2, 5'd6));
        add_instr(enc_r(7'h00, F3_SLL, OP_REG_W, 5'd19, 5'd3, 5'd1));
        add_instr(enc_r(7'h00, F3_SRL_SRA, OP_REG_W, 5'd20, 5'd2, 5'd1));
        add_instr(enc_r(7'h20, F3_SRL_SRA, OP_REG_W, 5'd21, 5'd2, 5'd1));
        add_instr(enc_i(12'h801, F3_ADD_SUB, OP_IMM_W, 5'd22, 5'd3));
        add_instr(enc_i({7'h00, 5'd17}, F3_SLL, OP_IMM_W, 5'd23, 5'd6));
        add_instr(enc_i({7'h00, 5'd9}, F3_SRL_SRA, OP_IMM_W, 5'd24, 5'd2));
        add_instr(enc_i({7'h20, 5'd9}, F3_SRL_SRA, OP_IMM_W, 5'd25, 5'd2));
        // Dependent chains through forwarding and write-through.
        add_instr(enc_i(12'd1, F3_ADD_SUB, OP_IMM, 5'd10, 5'd1));
        add_instr(enc_i(12'd1, F3_ADD_SUB, OP_IMM, 5'd11, 5'd10));
        add_instr(enc_r(7'h00, F3_ADD_SUB, OP_REG, 5'd12, 5'd10, 5'd11));
        add_instr(enc_i(12'd5, F3_ADD_SUB, OP_IMM, 5'd13, 5'd12));
        add_gap();
        add_instr(enc_r(7'h20, F3_ADD_SUB, OP_REG, 5'd14, 5'd13, 5'd12));
        // x0 stays zero.
        add_instr(enc_i(12'd5, F3_ADD_SUB, OP_IMM, 5'd0, 5'd1));
        add_instr(enc_r(7'h00, F3_ADD_SUB, OP_REG, 5'd15, 5'd0, 5'd1));
        add_instr(enc_r(7'h00, F3_OR, OP_REG, 5'd15, 5'd15, 5'd0));
        // Illegal opcode and a word form without a 32-bit variant.
        // Both aim at live registers, which the next add reads back.
        add_instr(enc_r(7'h00, 3'd0, 7'b0000011, 5'd10, 5'd1, 5'd2));
        add_instr(enc_r(7'h00, F3_XOR, OP_REG_W, 5'd11, 5'd1, 5'd2));
        add_instr(enc_r(7'h00, F3_ADD_SUB, OP_REG, 5'd17, 5'd10, 5'd11));
        add_gap();
    endtask

    // ------------------------------
    // Stimulus.
    // ------------------------------
    initial begin
        // A strobe held through reset must not reach the output.
        i_rst   = 1'b1;
        i_valid = 1'b1;
        i_instr = enc_i(12'd1, F3_ADD_SUB, OP_IMM, 5'd1, 5'd0);
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        build_table();
        cycle_limit = table_q.size() + 20;
        repeat (3) @(posedge clk);
        i_rst   <= 1'b0;
        i_valid <= 1'b0;
        // Idle cycle between reset and the first instruction.
        @(posedge clk);
        foreach (table_q[i]) begin
            @(posedge clk);
            i_valid <= table_q[i].valid;
            i_instr <= table_q[i].instr;
            if (table_q[i].valid) predict_result(table_q[i].instr);
        end
        @(posedge clk);
        i_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        // Room for any extra pulse.
        repeat (4) @(posedge clk);
        $display("Summary: %0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Results arrive in order and are sampled at the falling edge.
    always @(negedge clk) begin
        if (o_wb.valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected result at %0t: o_wb pulsed with nothing pending", $time);
            end else begin
                check_wb(o_wb, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d results never appeared", cycles, exp_q.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+.
rv_pkg.sv
rv_instr_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_exec_unit.sv
tb_rv_exec_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_rv_exec_unit -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
